// ==== common/arcade_pkg.sv ====
package arcade_pkg;

	// ==================================================
	// ROM image
	// ==================================================
	typedef logic [14:0] rom_addr_t;   // Byte address into the program ROM
	typedef logic [7:0]  rom_data_t;

	localparam int rom_depth = 32768;

	// ==================================================
	// Audio and video
	// ==================================================
	typedef logic [10:0] sample_t;     // Unsigned core sample
	typedef logic [1:0]  color_in2_t;  // Core red
	typedef logic [2:0]  color_in3_t;  // Core green and blue
	typedef logic [5:0]  color_out_t;

	typedef enum logic [1:0] {
		sl_off,
		sl_25,
		sl_50,
		sl_75
	} scanline_e;

	// ==================================================
	// Controls
	// ==================================================
	typedef logic [8:0] ctrl_t;
	typedef logic [7:0] joy_t;
	typedef logic [7:0] key_code_t;

	localparam int ctrl_up     = 0;
	localparam int ctrl_down   = 1;
	localparam int ctrl_left   = 2;
	localparam int ctrl_right  = 3;
	localparam int ctrl_fire   = 4;
	localparam int ctrl_bomb   = 5;
	localparam int ctrl_coin   = 6;
	localparam int ctrl_start1 = 7;
	localparam int ctrl_start2 = 8;

	// Joystick bit positions with 6 and 7 unused
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;
	localparam int joy_bomb  = 5;

	// PS/2 set 2 scan codes
	localparam key_code_t key_up     = 8'h75;
	localparam key_code_t key_down   = 8'h72;
	localparam key_code_t key_left   = 8'h6B;
	localparam key_code_t key_right  = 8'h74;
	localparam key_code_t key_coin   = 8'h76;  // ESC
	localparam key_code_t key_start1 = 8'h05;  // F1
	localparam key_code_t key_start2 = 8'h06;  // F2
	localparam key_code_t key_fire   = 8'h29;  // Space
	localparam key_code_t key_bomb   = 8'h11;  // Alt

endpackage

// ==== common/rom_if.sv ====
interface rom_if;

	logic                  we;
	logic                  rd;
	arcade_pkg::rom_addr_t addr;
	arcade_pkg::rom_data_t wdata;
	arcade_pkg::rom_data_t rdata;

	// Address, strobes and write data come from the loader
	modport loader (
		output we,
		output rd,
		output addr,
		output wdata,
		input  rdata
	);

	modport store (
		input  we,
		input  rd,
		input  addr,
		input  wdata,
		output rdata
	);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arcade shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module arcade_shell_tb -o sim_arcade --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_arcade)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
	exit 0
fi
exit 1

// ==== src.f ====
common/arcade_pkg.sv
common/rom_if.sv
src/rom_loader/rom_store.sv
src/rom_loader/rom_loader.sv
src/input_mapper.sv
src/video_out.sv
src/audio_dac.sv
src/arcade_shell.sv
verification/tb_clock.sv
verification/arcade_shell_tb.sv

// ==== src/arcade_shell.sv ====
module arcade_shell (
	input  logic                   clk_sys,
	input  logic                   rst_n,

	// Download stream
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  arcade_pkg::rom_addr_t  dl_addr,
	input  arcade_pkg::rom_data_t  dl_data,

	// Core program ROM
	input  logic                   cpu_rom_rd,
	input  arcade_pkg::rom_addr_t  cpu_rom_addr,
	output arcade_pkg::rom_data_t  cpu_rom_data,
	output logic                   cpu_rom_valid,

	input  logic                   reset_req,
	output logic                   rom_loaded,
	output logic                   game_reset,

	// Keyboard and joysticks
	input  logic                   key_strobe,
	input  logic                   key_pressed,
	input  arcade_pkg::key_code_t  key_code,
	input  arcade_pkg::joy_t       joystick_0,
	input  arcade_pkg::joy_t       joystick_1,
	input  logic                   rotate,
	output arcade_pkg::ctrl_t      controls,

	// Core video in, VGA out
	input  arcade_pkg::color_in2_t r_in,
	input  arcade_pkg::color_in3_t g_in,
	input  arcade_pkg::color_in3_t b_in,
	input  logic                   hs_in,
	input  logic                   vs_in,
	input  logic                   blank_n,
	input  arcade_pkg::scanline_e  scanlines,
	output arcade_pkg::color_out_t vga_r,
	output arcade_pkg::color_out_t vga_g,
	output arcade_pkg::color_out_t vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs,

	// Audio
	input  arcade_pkg::sample_t    sample,
	output logic                   audio_out
);

	rom_if rom_bus ();

	// ==================================================
	// ROM path
	// ==================================================
	rom_loader loader_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.dl_active     (dl_active),
		.dl_wr         (dl_wr),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.cpu_rom_rd    (cpu_rom_rd),
		.cpu_rom_addr  (cpu_rom_addr),
		.cpu_rom_data  (cpu_rom_data),
		.cpu_rom_valid (cpu_rom_valid),
		.reset_req     (reset_req),
		.rom_loaded    (rom_loaded),
		.game_reset    (game_reset),
		.bus           (rom_bus.loader)
	);

	rom_store store_i (
		.clk_sys (clk_sys),
		.bus     (rom_bus.store)
	);

	// ==================================================
	// Controls, video and audio
	// ==================================================
	input_mapper mapper_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotate      (rotate),
		.controls    (controls)
	);

	video_out video_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.r_in      (r_in),
		.g_in      (g_in),
		.b_in      (b_in),
		.hs_in     (hs_in),
		.vs_in     (vs_in),
		.blank_n   (blank_n),
		.scanlines (scanlines),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	audio_dac dac_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sample    (sample),
		.audio_out (audio_out)   // Same bit feeds both speaker channels on the board
	);

endmodule

// ==== src/audio_dac.sv ====
module audio_dac (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  arcade_pkg::sample_t sample,
	output logic                audio_out
);

	// ==================================================
	// First-order sigma-delta
	// ==================================================
	// Low 11 bits hold the running error, bit 11 the carry of the last add
	logic [11:0] acc;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[10:0]} + {1'b0, sample};
		end
	end

	// Pulse density is sample / 2048
	assign audio_out = acc[11];

endmodule

// ==== src/input_mapper.sv ====
module input_mapper (
	input  logic                  clk_sys,
	input  logic                  rst_n,

	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  arcade_pkg::key_code_t key_code,

	input  arcade_pkg::joy_t      joystick_0,
	input  arcade_pkg::joy_t      joystick_1,
	input  logic                  rotate,

	output arcade_pkg::ctrl_t     controls
);

	// Keyboard button state
	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_fire;
	logic btn_bomb;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;

	// Merged directions before rotation
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;

	// ==================================================
	// Key latches
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_fire   <= 1'b0;
			btn_bomb   <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				arcade_pkg::key_up:     btn_up     <= key_pressed;
				arcade_pkg::key_down:   btn_down   <= key_pressed;
				arcade_pkg::key_left:   btn_left   <= key_pressed;
				arcade_pkg::key_right:  btn_right  <= key_pressed;
				arcade_pkg::key_fire:   btn_fire   <= key_pressed;
				arcade_pkg::key_bomb:   btn_bomb   <= key_pressed;
				arcade_pkg::key_coin:   btn_coin   <= key_pressed;
				arcade_pkg::key_start1: btn_start1 <= key_pressed;
				arcade_pkg::key_start2: btn_start2 <= key_pressed;
				default: ;   // Other keys ignored
			endcase
		end
	end

	// ==================================================
	// Merge and rotation
	// ==================================================
	assign m_up    = btn_up | joystick_0[arcade_pkg::joy_up] | joystick_1[arcade_pkg::joy_up];
	assign m_down  = btn_down | joystick_0[arcade_pkg::joy_down] |
	                 joystick_1[arcade_pkg::joy_down];
	assign m_left  = btn_left | joystick_0[arcade_pkg::joy_left] |
	                 joystick_1[arcade_pkg::joy_left];
	assign m_right = btn_right | joystick_0[arcade_pkg::joy_right] |
	                 joystick_1[arcade_pkg::joy_right];

	always_comb begin
		controls = '0;
		// Rotated cabinet turns the stick a quarter turn
		controls[arcade_pkg::ctrl_up]     = rotate ? m_left  : m_up;
		controls[arcade_pkg::ctrl_down]   = rotate ? m_right : m_down;
		controls[arcade_pkg::ctrl_left]   = rotate ? m_down  : m_left;
		controls[arcade_pkg::ctrl_right]  = rotate ? m_up    : m_right;
		controls[arcade_pkg::ctrl_fire]   = btn_fire | joystick_0[arcade_pkg::joy_fire] |
		                                    joystick_1[arcade_pkg::joy_fire];
		controls[arcade_pkg::ctrl_bomb]   = btn_bomb | joystick_0[arcade_pkg::joy_bomb] |
		                                    joystick_1[arcade_pkg::joy_bomb];
		controls[arcade_pkg::ctrl_coin]   = btn_coin;
		controls[arcade_pkg::ctrl_start1] = btn_start1;
		controls[arcade_pkg::ctrl_start2] = btn_start2;
	end

endmodule

// ==== src/rom_loader/rom_loader.sv ====
module rom_loader (
	input  logic                  clk_sys,
	input  logic                  rst_n,

	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  arcade_pkg::rom_addr_t dl_addr,
	input  arcade_pkg::rom_data_t dl_data,

	input  logic                  cpu_rom_rd,
	input  arcade_pkg::rom_addr_t cpu_rom_addr,
	output arcade_pkg::rom_data_t cpu_rom_data,
	output logic                  cpu_rom_valid,

	input  logic                  reset_req,
	output logic                  rom_loaded,
	output logic                  game_reset,

	rom_if.loader                 bus
);

	logic dl_active_q;   // Previous dl_active
	logic dl_done;       // Registered falling edge of dl_active

	// ==================================================
	// Memory port steering
	// ==================================================
	// Download owns the port for the whole transfer
	assign bus.addr  = dl_active ? dl_addr : cpu_rom_addr;
	assign bus.wdata = dl_data;
	assign bus.we    = dl_active & dl_wr;
	assign bus.rd    = !dl_active & cpu_rom_rd;   // Core reads dropped during download

	assign cpu_rom_data = bus.rdata;

	// Store answers one edge after the strobe
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cpu_rom_valid <= 1'b0;
		end else begin
			cpu_rom_valid <= bus.rd;
		end
	end

	// ==================================================
	// Load tracking and game reset
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_active_q <= 1'b0;
			dl_done     <= 1'b0;
			rom_loaded  <= 1'b0;
			game_reset  <= 1'b1;
		end else begin
			dl_active_q <= dl_active;
			dl_done     <= dl_active_q & !dl_active;
			if (dl_done) begin
				rom_loaded <= 1'b1;   // Sticky until the next board reset
			end
			// Hold the core while the ROM is missing
			game_reset <= reset_req | !rom_loaded;
		end
	end

endmodule

// ==== src/rom_loader/rom_store.sv ====
module rom_store (
	input  logic clk_sys,
	rom_if.store bus
);

	// ==================================================
	// ROM image, filled by the download stream
	// ==================================================
	arcade_pkg::rom_data_t mem [arcade_pkg::rom_depth];

	// Write port, one byte per download strobe
	always_ff @(posedge clk_sys) begin
		if (bus.we) begin
			mem[bus.addr] <= bus.wdata;
		end
	end

	// Read port
	// Data is held between reads so the core may sample it late
	always_ff @(posedge clk_sys) begin
		if (bus.rd) begin
			bus.rdata <= mem[bus.addr];
		end
	end

endmodule

// ==== src/video_out.sv ====
module video_out (
	input  logic                   clk_sys,
	input  logic                   rst_n,

	input  arcade_pkg::color_in2_t r_in,
	input  arcade_pkg::color_in3_t g_in,
	input  arcade_pkg::color_in3_t b_in,
	input  logic                   hs_in,
	input  logic                   vs_in,
	input  logic                   blank_n,
	input  arcade_pkg::scanline_e  scanlines,

	output arcade_pkg::color_out_t vga_r,
	output arcade_pkg::color_out_t vga_g,
	output arcade_pkg::color_out_t vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs
);

	arcade_pkg::color_in3_t r_wide;   // Red padded to three bits
	arcade_pkg::color_out_t r_pix;
	arcade_pkg::color_out_t g_pix;
	arcade_pkg::color_out_t b_pix;
	logic                   odd_line;

	// Bit replication keeps full white at 6'h3F
	function automatic arcade_pkg::color_out_t widen(input arcade_pkg::color_in3_t c);
		return {c, c};
	endfunction

	function automatic arcade_pkg::color_out_t dim(input arcade_pkg::color_out_t v,
	                                               input arcade_pkg::scanline_e mode);
		case (mode)
			arcade_pkg::sl_25: return v - (v >> 2);
			arcade_pkg::sl_50: return v >> 1;
			arcade_pkg::sl_75: return v >> 2;
			default:           return v;
		endcase
	endfunction

	assign r_wide = {r_in, r_in[1]};

	always_comb begin
		r_pix = widen(r_wide);
		g_pix = widen(g_in);
		b_pix = widen(b_in);
		if (odd_line) begin
			r_pix = dim(r_pix, scanlines);
			g_pix = dim(g_pix, scanlines);
			b_pix = dim(b_pix, scanlines);
		end
		if (!blank_n) begin
			r_pix = '0;
			g_pix = '0;
			b_pix = '0;
		end
	end

	// ==================================================
	// Output registers and line parity
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			vga_r  <= r_pix;
			vga_g  <= g_pix;
			vga_b  <= b_pix;
			vga_hs <= hs_in;
			vga_vs <= vs_in;
			if (vs_in) begin
				odd_line <= 1'b0;   // Every frame starts on an even line
			end else if (hs_in && !vga_hs) begin
				odd_line <= !odd_line;   // vga_hs is last cycle's hs_in
			end
		end
	end

endmodule

// ==== verification/arcade_shell_tb.sv ====
module arcade_shell_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// ==================================================
	// Test lengths and run limit
	// ==================================================
	localparam int n_pre_load   = 16;
	localparam int n_early_ops  = 16;
	localparam int n_dl_bytes   = 512;
	localparam int n_reads      = 200;
	localparam int n_key_events = 300;
	localparam int n_joy_steps  = 100;
	localparam int n_lines      = 8;
	localparam int line_len     = 16;
	localparam int n_samples    = 8;
	localparam int audio_window = 2048;
	localparam int test_cycles  = n_pre_load + 2 * n_early_ops + 16 + n_dl_bytes
	                              + 2 * n_reads + 2 * n_key_events + 2 * n_joy_steps
	                              + 4 * n_lines * line_len + n_samples * (audio_window + 4) + 64;
	localparam int watchdog_cycles = 2 * test_cycles;

	typedef enum {
		chk_rom_data,
		chk_rom_valid,
		chk_rom_loaded,
		chk_game_reset,
		chk_audio_out,
		chk_controls,
		chk_vga_r,
		chk_vga_g,
		chk_vga_b,
		chk_vga_hs,
		chk_vga_vs,
		chk_audio_ones
	} chk_e;

	// One pending comparison, due at a given cycle
	typedef struct packed {
		int   due;
		chk_e kind;
		int   want;
		int   got;
	} expect_t;

	logic                   clk_sys;
	logic                   rst_n;
	logic                   dl_active;
	logic                   dl_wr;
	arcade_pkg::rom_addr_t  dl_addr;
	arcade_pkg::rom_data_t  dl_data;
	logic                   cpu_rom_rd;
	arcade_pkg::rom_addr_t  cpu_rom_addr;
	arcade_pkg::rom_data_t  cpu_rom_data;
	logic                   cpu_rom_valid;
	logic                   reset_req;
	logic                   rom_loaded;
	logic                   game_reset;
	logic                   key_strobe;
	logic                   key_pressed;
	arcade_pkg::key_code_t  key_code;
	arcade_pkg::joy_t       joystick_0;
	arcade_pkg::joy_t       joystick_1;
	logic                   rotate;
	arcade_pkg::ctrl_t      controls;
	arcade_pkg::color_in2_t r_in;
	arcade_pkg::color_in3_t g_in;
	arcade_pkg::color_in3_t b_in;
	logic                   hs_in;
	logic                   vs_in;
	logic                   blank_n;
	arcade_pkg::scanline_e  scanlines;
	arcade_pkg::color_out_t vga_r;
	arcade_pkg::color_out_t vga_g;
	arcade_pkg::color_out_t vga_b;
	logic                   vga_hs;
	logic                   vga_vs;
	arcade_pkg::sample_t    sample;
	logic                   audio_out;

	arcade_pkg::rom_data_t  rom_model [arcade_pkg::rom_depth];
	arcade_pkg::rom_addr_t  written_q [$];
	logic [8:0]             btn_model;   // Keyboard buttons in control bit order
	expect_t                exp_q [$];
	expect_t                cur;
	int                     cycle = 0;
	int                     n_checks = 0;
	int                     n_errors = 0;
	int                     check_mark = 0;
	int                     err_mark = 0;

	tb_clock clk_gen_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	arcade_shell dut_i (.*);

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
	end

	// ==================================================
	// Reference models
	// ==================================================
	function automatic logic [8:0] key_mask(input logic [7:0] code);
		case (code)
			8'h75:   return 9'h001;   // Up
			8'h72:   return 9'h002;
			8'h6B:   return 9'h004;
			8'h74:   return 9'h008;
			8'h29:   return 9'h010;   // Fire
			8'h11:   return 9'h020;
			8'h76:   return 9'h040;   // Coin
			8'h05:   return 9'h080;
			8'h06:   return 9'h100;
			default: return 9'h000;
		endcase
	endfunction

	function automatic logic [7:0] key_code_of(input int i);
		case (i)
			0:       return 8'h75;
			1:       return 8'h72;
			2:       return 8'h6B;
			3:       return 8'h74;
			4:       return 8'h29;
			5:       return 8'h11;
			6:       return 8'h76;
			7:       return 8'h05;
			default: return 8'h06;
		endcase
	endfunction

	function automatic logic [8:0] ref_controls(input logic [8:0] btn, input logic [7:0] j0,
	                                            input logic [7:0] j1, input logic rot);
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic [8:0] c;
		up    = btn[0] | j0[3] | j1[3];
		down  = btn[1] | j0[2] | j1[2];
		left  = btn[2] | j0[1] | j1[1];
		right = btn[3] | j0[0] | j1[0];
		c[0] = rot ? left : up;      // Quarter turn for a rotated cabinet
		c[1] = rot ? right : down;
		c[2] = rot ? down : left;
		c[3] = rot ? up : right;
		c[4] = btn[4] | j0[4] | j1[4];
		c[5] = btn[5] | j0[5] | j1[5];
		c[8:6] = btn[8:6];
		return c;
	endfunction

	function automatic logic [5:0] ref_pixel(input logic [2:0] c, input logic vis,
	                                         input logic odd, input logic [1:0] mode);
		logic [5:0] v;
		v = {c, c};
		if (odd) begin
			case (mode)
				2'd1:    v = v - v / 6'd4;
				2'd2:    v = v / 6'd2;
				2'd3:    v = v / 6'd4;
				default: ;
			endcase
		end
		return vis ? v : 6'd0;
	endfunction

	function automatic int ref_ones(input arcade_pkg::sample_t s);
		return int'(s);   // Pulse density s/2048 over a 2048 cycle window
	endfunction

	// ==================================================
	// Compare tasks and checking process
	// ==================================================
	task automatic check_rom_data(input string name, input arcade_pkg::rom_data_t want,
	                              input arcade_pkg::rom_data_t got);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[FAIL] %s expected %h got %h at %0t", name, want, got, $time);
		end
	endtask

	task automatic check_controls(input string name, input arcade_pkg::ctrl_t want,
	                              input arcade_pkg::ctrl_t got);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[FAIL] %s expected %h got %h at %0t", name, want, got, $time);
		end
	endtask

	task automatic check_color(input string name, input arcade_pkg::color_out_t want,
	                           input arcade_pkg::color_out_t got);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[FAIL] %s expected %h got %h at %0t", name, want, got, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic want, input logic got);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[FAIL] %s expected %h got %h at %0t", name, want, got, $time);
		end
	endtask

	task automatic check_count(input string name, input int want, input int got);
		n_checks++;
		if (got < want - 1 || got > want + 1) begin   // One count of slack
			n_errors++;
			$display("[FAIL] %s expected %h got %h at %0t", name, want, got, $time);
		end
	endtask

	always @(negedge clk_sys) begin
		#1;   // Falling-edge drives settle first
		while (exp_q.size() > 0 && exp_q[0].due <= cycle) begin
			cur = exp_q.pop_front();
			case (cur.kind)
				chk_rom_data:   check_rom_data("cpu_rom_data", arcade_pkg::rom_data_t'(cur.want),
				                               cpu_rom_data);
				chk_rom_valid:  check_bit("cpu_rom_valid", cur.want[0], cpu_rom_valid);
				chk_rom_loaded: check_bit("rom_loaded", cur.want[0], rom_loaded);
				chk_game_reset: check_bit("game_reset", cur.want[0], game_reset);
				chk_audio_out:  check_bit("audio_out", cur.want[0], audio_out);
				chk_controls:   check_controls("controls", arcade_pkg::ctrl_t'(cur.want), controls);
				chk_vga_r:      check_color("vga_r", arcade_pkg::color_out_t'(cur.want), vga_r);
				chk_vga_g:      check_color("vga_g", arcade_pkg::color_out_t'(cur.want), vga_g);
				chk_vga_b:      check_color("vga_b", arcade_pkg::color_out_t'(cur.want), vga_b);
				chk_vga_hs:     check_bit("vga_hs", cur.want[0], vga_hs);
				chk_vga_vs:     check_bit("vga_vs", cur.want[0], vga_vs);
				chk_audio_ones: check_count("audio_out ones", cur.want, cur.got);
				default:        ;
			endcase
		end
	end

	// ==================================================
	// Stimulus helpers
	// ==================================================
	task automatic expect_val(input int delay, input chk_e kind, input int want, input int got);
		expect_t e;
		e.due  = cycle + delay;
		e.kind = kind;
		e.want = want;
		e.got  = got;
		exp_q.push_back(e);
	endtask

	task automatic drive_write(input arcade_pkg::rom_addr_t addr,
	                           input arcade_pkg::rom_data_t data);
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
		rom_model[addr] = data;
		written_q.push_back(addr);
	endtask

	task automatic wait_loaded();
		int  waited;
		logic ready;
		waited = 0;
		ready  = 1'b0;
		while (!ready && waited < 16) begin
			@(negedge clk_sys);
			waited++;
			ready = rom_loaded && !game_reset;
		end
		if (!ready) begin
			n_errors++;
			$display("rom_loaded did not rise or game_reset did not fall after the download");
		end
	endtask

	task automatic finish_test(input string name);
		repeat (3) @(negedge clk_sys);   // Let pending compares drain
		$display("%s: %0d checks, %0d errors", name, n_checks - check_mark,
		         n_errors - err_mark);
		check_mark = n_checks;
		err_mark   = n_errors;
	endtask

	// ==================================================
	// Tests
	// ==================================================
	task automatic exercise_reset_rules();
		repeat (n_pre_load) begin
			@(negedge clk_sys);
			expect_val(1, chk_game_reset, 1, 0);   // Nothing downloaded yet
			expect_val(1, chk_rom_loaded, 0, 0);
			expect_val(1, chk_rom_valid, 0, 0);
			expect_val(1, chk_controls, 0, 0);
			expect_val(1, chk_vga_r, 0, 0);
			expect_val(1, chk_audio_out, 0, 0);
		end
		@(negedge clk_sys);
		dl_active = 1'b1;
		repeat (n_early_ops) begin
			@(negedge clk_sys);
			drive_write(arcade_pkg::rom_addr_t'($urandom), arcade_pkg::rom_data_t'($urandom));
			cpu_rom_rd   = 1'b1;
			cpu_rom_addr = arcade_pkg::rom_addr_t'($urandom);
			expect_val(1, chk_rom_valid, 0, 0);
			@(negedge clk_sys);
			dl_wr      = 1'b0;
			cpu_rom_rd = 1'b0;
			expect_val(1, chk_rom_valid, 0, 0);
		end
		@(negedge clk_sys);
		dl_active = 1'b0;
		// Edge registered, then loaded, then the game reset follows
		expect_val(1, chk_rom_loaded, 0, 0);
		expect_val(2, chk_rom_loaded, 1, 0);
		expect_val(2, chk_game_reset, 1, 0);
		expect_val(3, chk_game_reset, 0, 0);
		repeat (4) @(negedge clk_sys);
		reset_req = 1'b1;
		expect_val(1, chk_game_reset, 1, 0);
		repeat (3) begin
			@(negedge clk_sys);
			expect_val(1, chk_game_reset, 1, 0);
		end
		@(negedge clk_sys);
		reset_req = 1'b0;
		expect_val(1, chk_game_reset, 0, 0);
		finish_test("reset and download rules");
	endtask

	task automatic load_and_read_rom();
		arcade_pkg::rom_addr_t addr;
		@(negedge clk_sys);
		dl_active = 1'b1;
		repeat (n_dl_bytes) begin
			@(negedge clk_sys);
			drive_write(arcade_pkg::rom_addr_t'($urandom), arcade_pkg::rom_data_t'($urandom));
		end
		@(negedge clk_sys);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		wait_loaded();
		repeat (n_reads) begin
			addr = written_q[$urandom_range(0, written_q.size() - 1)];
			cpu_rom_rd   = 1'b1;
			cpu_rom_addr = addr;
			expect_val(1, chk_rom_valid, 1, 0);
			expect_val(1, chk_rom_data, int'(rom_model[addr]), 0);
			@(negedge clk_sys);
			cpu_rom_rd = 1'b0;
			expect_val(1, chk_rom_valid, 0, 0);   // Valid is a single pulse
			@(negedge clk_sys);
		end
		finish_test("ROM load and read-back");
	endtask

	task automatic press_random_keys();
		logic [7:0] code;
		logic       pressed;
		logic [8:0] m;
		rotate     = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		repeat (n_key_events) begin
			@(negedge clk_sys);
			if ($urandom_range(0, 1) == 1) begin
				code = key_code_of(int'($urandom_range(0, 8)));
			end else begin
				code = arcade_pkg::key_code_t'($urandom);   // Mostly unmapped
			end
			pressed     = 1'($urandom);
			key_strobe  = 1'b1;
			key_code    = code;
			key_pressed = pressed;
			m = key_mask(code);
			btn_model = pressed ? (btn_model | m) : (btn_model & ~m);
			expect_val(1, chk_controls, int'(ref_controls(btn_model, 8'h00, 8'h00, 1'b0)), 0);
			@(negedge clk_sys);
			key_strobe = 1'b0;
		end
		finish_test("keyboard latches");
	endtask

	task automatic sweep_joysticks();
		repeat (n_joy_steps) begin
			@(negedge clk_sys);
			joystick_0 = arcade_pkg::joy_t'($urandom & $urandom);   // Sparse bits
			joystick_1 = arcade_pkg::joy_t'($urandom & $urandom);
			rotate     = 1'($urandom);
			// Same cycle, no clock edge in between
			expect_val(0, chk_controls,
			           int'(ref_controls(btn_model, joystick_0, joystick_1, rotate)), 0);
			@(negedge clk_sys);
		end
		joystick_0 = '0;
		joystick_1 = '0;
		rotate     = 1'b0;
		finish_test("joystick merge and rotation");
	endtask

	task automatic stream_video_lines();
		logic odd;
		logic hs_prev;
		logic vs_line;
		int   hs_w;
		odd     = 1'b0;
		hs_prev = 1'b0;
		for (int mode = 0; mode < 4; mode++) begin
			for (int line = 0; line < n_lines; line++) begin
				vs_line = ($urandom_range(0, 4) == 0);
				hs_w    = int'($urandom_range(1, 4));
				for (int col = 0; col < line_len; col++) begin
					@(negedge clk_sys);
					r_in      = arcade_pkg::color_in2_t'($urandom);
					g_in      = arcade_pkg::color_in3_t'($urandom);
					b_in      = arcade_pkg::color_in3_t'($urandom);
					blank_n   = ($urandom_range(0, 3) != 0);
					hs_in     = (col >= line_len - hs_w);
					vs_in     = vs_line;
					scanlines = arcade_pkg::scanline_e'(2'(mode));
					expect_val(1, chk_vga_r,
					           int'(ref_pixel({r_in, r_in[1]}, blank_n, odd, 2'(mode))), 0);
					expect_val(1, chk_vga_g, int'(ref_pixel(g_in, blank_n, odd, 2'(mode))), 0);
					expect_val(1, chk_vga_b, int'(ref_pixel(b_in, blank_n, odd, 2'(mode))), 0);
					expect_val(1, chk_vga_hs, int'(hs_in), 0);
					expect_val(1, chk_vga_vs, int'(vs_in), 0);
					// Parity seen by the next pixel
					if (vs_in) begin
						odd = 1'b0;
					end else if (hs_in && !hs_prev) begin
						odd = !odd;
					end
					hs_prev = hs_in;
				end
			end
		end
		@(negedge clk_sys);
		hs_in = 1'b0;
		vs_in = 1'b0;
		finish_test("video path");
	endtask

	task automatic measure_audio_density();
		arcade_pkg::sample_t s;
		int                  ones;
		for (int i = 0; i < n_samples; i++) begin
			@(negedge clk_sys);
			if (i == 0) begin
				s = 11'd0;
			end else if (i == 1) begin
				s = 11'd2047;
			end else begin
				s = arcade_pkg::sample_t'($urandom);
			end
			sample = s;
			repeat (2) @(negedge clk_sys);
			ones = 0;
			repeat (audio_window) begin
				if (audio_out) begin
					ones++;
				end
				@(negedge clk_sys);
			end
			expect_val(1, chk_audio_ones, ref_ones(s), ones);
		end
		finish_test("audio sigma-delta");
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================
	initial begin
		void'($urandom(37));
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		cpu_rom_rd   = 1'b0;
		cpu_rom_addr = '0;
		reset_req    = 1'b0;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_code     = '0;
		joystick_0   = '0;
		joystick_1   = '0;
		rotate       = 1'b0;
		r_in         = '0;
		g_in         = '0;
		b_in         = '0;
		hs_in        = 1'b0;
		vs_in        = 1'b0;
		blank_n      = 1'b0;
		scanlines    = arcade_pkg::sl_off;
		sample       = '0;
		btn_model    = '0;
		wait (rst_n === 1'b1);
		@(negedge clk_sys);
		exercise_reset_rules();
		load_and_read_rom();
		press_random_keys();
		sweep_joysticks();
		stream_video_lines();
		measure_audio_density();
		$display("Total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
		$display("test failed");
		$finish;
	end

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
	output logic clk_sys,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 5;

	// 100 MHz system clock
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;   // Released between edges
	end

endmodule
